// File: verilog/fetchPkg.sv
// Fetch stage shared definitions
// Opcode and forwarding-select enums, the later-stage status word,
// the forwarding control pair and the fetch slot handed to decode.
// Field positions follow the 16-bit, eight-register teaching ISA.
package fetchPkg;

   localparam int addrWidth   = 16;                     // Instruction and address width
   localparam int opWidth     = 5;                      // Opcode field size
   localparam int regWidth    = 3;                      // Eight registers
   localparam int opLsb       = 11;                     // Opcode in bits 15 to 11
   localparam int rsLsb       = 8;                      // Rs in bits 10 to 8
   localparam int rtLsb       = 5;                      // Rt in bits 7 to 5
   localparam int lineWords   = 4;                      // Words per buffered line
   localparam int lineOffBits = $clog2(2 * lineWords);  // Byte offset inside a line

   // Opcodes that matter to hazard decode
   typedef enum logic [opWidth-1:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opAddi = 5'b01000,
      opLd   = 5'b10001,
      opSt   = 5'b10000,
      opBeqz = 5'b01100,
      opJ    = 5'b00100,
      opAlu  = 5'b11011   // Register-register group
   } instrOp;

   // Operand source for the execute stage
   typedef enum logic [1:0] {
      fwdNone = 2'b00,   // Register file value
      fwdX    = 2'b01,   // Result leaving execute
      fwdM    = 2'b10,   // Result leaving memory
      fwdW    = 2'b11    // Writeback value
   } fwdSel;

   // Status of one later pipeline stage, 6 bits
   typedef struct packed {
      logic                regWrt;     // Stage writes a register
      logic [regWidth-1:0] wrtReg;     // Destination register
      logic                isLoad;     // Result comes from data memory
      logic                isBranch;   // Control transfer in flight
   } stageInfo;

   // Forwarding selects for both operands, 4 bits
   typedef struct packed {
      fwdSel fwdA;   // Rs source
      fwdSel fwdB;   // Rt source
   } fwdCtrl;

   // Fetch slot to decode, 34 bits
   typedef struct packed {
      logic [addrWidth-1:0] instruction;
      logic [addrWidth-1:0] incPC;        // Address of the next word
      logic                 instrValid;   // Memory delivered this cycle
      logic                 bubble;       // Inserted nop
   } fetchOut;

   // Encoding of a nop
   localparam logic [addrWidth-1:0] nopWord = {opNop, {(addrWidth - opWidth){1'b0}}};

endpackage

// File: verilog/instrMemory.sv
// Instruction memory with a variable-latency model
// A one-line buffer sits in front of a slow word array. A fetch inside the
// buffered line returns one cycle later. Any other fetch stalls for
// missLatency cycles, returns the word the cycle after and refills the line.
// Odd addresses return a nop together with alignErr. The array is written
// only through the preload port.
module instrMemory #(
   parameter int missLatency = 3,     // Extra cycles per miss, at least 1
   parameter int memWords    = 256    // Array depth in words
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [fetchPkg::addrWidth-1:0] addr,       // Byte address
   input  logic                           freeze,     // No new accesses
   input  logic                           loadEn,
   input  logic [fetchPkg::addrWidth-1:0] loadAddr,   // Byte address
   input  logic [fetchPkg::addrWidth-1:0] loadData,
   output logic [fetchPkg::addrWidth-1:0] word,
   output logic                           done,
   output logic                           stall,
   output logic                           alignErr
);

   import fetchPkg::*;

   localparam int idxBits = $clog2(memWords);
   localparam int cntBits = $clog2(missLatency + 1);
   localparam int tagBits = addrWidth - lineOffBits;

   logic [addrWidth-1:0] memArray [memWords];   // Slow backing array
   logic [tagBits-1:0]   lineTag;               // Line held in the buffer
   logic                 tagValid;
   logic [cntBits-1:0]   missCnt;               // Miss cycles left
   logic [idxBits-1:0]   rdIdx;
   logic [idxBits-1:0]   wrIdx;
   logic [addrWidth-1:0] rdWord;
   logic                 lineHit;
   logic                 fillLast;              // Final miss cycle
   logic                 accept;                // Served from the buffer
   logic                 missStart;

   assign rdIdx  = addr[idxBits:1];       // Word index, byte bit dropped
   assign wrIdx  = loadAddr[idxBits:1];
   assign rdWord = addr[0] ? nopWord : memArray[rdIdx];

   assign lineHit = tagValid && (addr[addrWidth-1:lineOffBits] == lineTag);
   assign stall   = (missCnt != '0);

   assign fillLast  = stall && (missCnt == cntBits'(1));
   // Odd addresses never go to the array
   assign accept    = !stall && !freeze && (addr[0] || lineHit);
   assign missStart = !stall && !freeze && !addr[0] && !lineHit;

   // Preload port
   always_ff @(posedge clk) begin
      if (loadEn) begin
         memArray[wrIdx] <= loadData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         missCnt  <= '0;
         done     <= 1'b0;
         tagValid <= 1'b0;
         alignErr <= 1'b0;
      end else begin
         alignErr <= addr[0];              // Follows the presented address
         done     <= fillLast || accept;   // One cycle after the access
         if (missStart) begin
            missCnt <= cntBits'(missLatency);
         end else if (stall) begin
            missCnt <= missCnt - 1'b1;
         end
         if (fillLast && !addr[0]) begin
            tagValid <= 1'b1;               // Buffer holds a real line now
         end
      end
   end

   // Word and tag registers
   always_ff @(posedge clk) begin
      if (fillLast || accept) begin
         word <= rdWord;
      end
      if (fillLast && !addr[0]) begin
         lineTag <= addr[addrWidth-1:lineOffBits];
      end
   end

   // Busy and delivering are exclusive
   assert property (@(posedge clk) disable iff (reset) !(stall && done))
      else $error("instrMemory: stall and done high together");

   assert property (@(posedge clk) disable iff (reset) missCnt <= cntBits'(missLatency))
      else $error("instrMemory: miss counter above missLatency");

endmodule

// File: verilog/hazardDetect.sv
// Hazard detection and forwarding for the fetched instruction
// Decodes which source registers the word reads, then compares them with
// the destinations of decode, execute, memory and writeback. A branch in
// flight flushes the slot, a load in decode feeding this word inserts one
// bubble, and the forwarding selects pick the youngest producer.
// Purely combinational.
module hazardDetect (
   input  logic [fetchPkg::addrWidth-1:0] memWord,
   input  logic                           memDone,
   input  fetchPkg::stageInfo             stageD,
   input  fetchPkg::stageInfo             stageX,
   input  fetchPkg::stageInfo             stageM,
   input  fetchPkg::stageInfo             stageW,
   output logic [fetchPkg::addrWidth-1:0] slot,      // Word passed to decode
   output logic                           bubble,    // Slot is an inserted nop
   output logic                           pcHold,    // Refetch the same PC
   output fetchPkg::fwdCtrl               fwd
);

   import fetchPkg::*;

   instrOp              op;
   logic [regWidth-1:0] rs;
   logic [regWidth-1:0] rt;
   logic                readsRs;
   logic                readsRt;
   logic                flush;
   logic                loadUse;

   // Youngest producer of src, X before M before W
   function automatic fwdSel pickSrc(
      input logic [regWidth-1:0] src,
      input stageInfo            sx,
      input stageInfo            sm,
      input stageInfo            sw
   );
      fwdSel sel;
      sel = fwdNone;
      if (sx.regWrt && !sx.isLoad && (sx.wrtReg == src)) begin
         sel = fwdX;                         // Load data not ready in X
      end else if (sm.regWrt && (sm.wrtReg == src)) begin
         sel = fwdM;
      end else if (sw.regWrt && (sw.wrtReg == src)) begin
         sel = fwdW;
      end
      return sel;
   endfunction

   assign op = instrOp'(memWord[opLsb +: opWidth]);
   assign rs = memWord[rsLsb +: regWidth];
   assign rt = memWord[rtLsb +: regWidth];

   // Source register usage per opcode
   always_comb begin
      readsRs = 1'b1;
      readsRt = 1'b0;
      case (op)
         opHalt, opNop, opJ: begin
            readsRs = 1'b0;                  // No register operands
         end
         opSt, opAlu: begin
            readsRt = 1'b1;                  // Both operands
         end
         opAddi, opLd, opBeqz: begin
            readsRt = 1'b0;                  // Rs only
         end
         default: begin
            readsRt = 1'b0;                  // Unknown codes read rs only
         end
      endcase
   end

   // Branch in D, X or M not yet resolved
   assign flush = stageD.isBranch || stageX.isBranch || stageM.isBranch;

   // Load in D writes a register this word needs
   assign loadUse = memDone && stageD.regWrt && stageD.isLoad &&
                    ((readsRs && (stageD.wrtReg == rs)) ||
                     (readsRt && (stageD.wrtReg == rt)));

   assign pcHold = flush || loadUse;
   assign bubble = memDone && pcHold;
   assign slot   = (memDone && !pcHold) ? memWord : nopWord;

   // Selects only for a real instruction
   always_comb begin
      fwd.fwdA = fwdNone;
      fwd.fwdB = fwdNone;
      if (memDone && !pcHold) begin
         if (readsRs) begin
            fwd.fwdA = pickSrc(rs, stageX, stageM, stageW);
         end
         if (readsRt) begin
            fwd.fwdB = pickSrc(rt, stageX, stageM, stageW);
         end
      end
   end

   // A held PC always leaves a nop in the slot
   always_comb begin
      if (memDone && pcHold) begin
         assert (bubble && (slot == nopWord) && (fwd == '0))
            else $error("hazardDetect: PC held without a nop bubble");
      end
   end

endmodule

// File: verilog/fetch.sv
// Instruction fetch stage
// Holds the program counter and steps it by two per delivered instruction.
// A branch resolved in writeback redirects to newPC, hazards and createDump
// hold it. The next PC goes straight to the instruction memory so a run of
// line hits delivers one word per cycle. Hazard logic shapes the slot and
// the forwarding selects. Flags a misaligned fetch and a PC carry-out.
module fetch #(
   parameter int missLatency = 3,    // Miss penalty in cycles
   parameter int memWords    = 256   // Instruction memory depth
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [fetchPkg::addrWidth-1:0] newPC,       // Branch target from W
   input  logic                           createDump,  // Freeze the PC
   input  fetchPkg::stageInfo             stageD,
   input  fetchPkg::stageInfo             stageX,
   input  fetchPkg::stageInfo             stageM,
   input  fetchPkg::stageInfo             stageW,
   input  logic                           loadEn,
   input  logic [fetchPkg::addrWidth-1:0] loadAddr,
   input  logic [fetchPkg::addrWidth-1:0] loadData,
   output fetchPkg::fetchOut              fetched,
   output fetchPkg::fwdCtrl               fwd,
   output logic                           stall,       // Memory busy
   output logic                           alignErr,
   output logic                           err          // PC increment carry
);

   import fetchPkg::*;

   logic [addrWidth-1:0] pcReg;    // Address of the word in the slot
   logic [addrWidth-1:0] pcAddr;   // Next PC, presented to memory
   logic [addrWidth-1:0] incPC;
   logic                 incCarry;
   logic [addrWidth-1:0] memWord;
   logic                 memDone;
   logic                 pcHold;
   logic [addrWidth-1:0] slot;
   logic                 bubble;

   assign {incCarry, incPC} = {1'b0, pcReg} + (addrWidth + 1)'(2);
   assign err = incCarry;          // Wraps past 16'hFFFE

   // Redirect wins over everything
   always_comb begin
      if (stageW.isBranch) begin
         pcAddr = newPC;
      end else if (memDone && !pcHold && !createDump) begin
         pcAddr = incPC;
      end else begin
         pcAddr = pcReg;           // Miss, hazard or dump
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pcReg <= '0;
      end else begin
         pcReg <= pcAddr;
      end
   end

   instrMemory #(
      .missLatency(missLatency),
      .memWords   (memWords)
   ) imem0 (
      .clk     (clk),
      .reset   (reset),
      .addr    (pcAddr),
      .freeze  (createDump),
      .loadEn  (loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .word    (memWord),
      .done    (memDone),
      .stall   (stall),
      .alignErr(alignErr)
   );

   hazardDetect hazard0 (
      .memWord(memWord),
      .memDone(memDone),
      .stageD (stageD),
      .stageX (stageX),
      .stageM (stageM),
      .stageW (stageW),
      .slot   (slot),
      .bubble (bubble),
      .pcHold (pcHold),
      .fwd    (fwd)
   );

   // Slot to decode
   assign fetched.instruction = slot;
   assign fetched.incPC       = incPC;
   assign fetched.instrValid  = memDone;
   assign fetched.bubble      = bubble;

   // An odd PC is always flagged by the memory
   assert property (@(posedge clk) disable iff (reset) !pcReg[0] || alignErr)
      else $error("fetch: odd PC %h without alignErr", pcReg);

endmodule

// File: verification/fetchTb.sv
// Testbench for the instruction fetch stage
// Preloads a program, then walks a table of pipeline-status rows through
// the DUT. A model of the PC stream and the one-line buffer supplies the
// expected word, miss stalls and error flags for each delivered slot.
module fetchTb;

   timeunit 1ns;
   timeprecision 100ps;

   import fetchPkg::*;

   localparam int missLat   = 3;
   localparam int memWords  = 256;
   localparam int resetCyc  = 8;
   localparam int numRows   = 24;
   localparam int limitCyc  = resetCyc + memWords + numRows * (missLat + 2) * 2;

   typedef enum logic [1:0] {kPlain, kRedir, kDump} rowKind;

   typedef struct packed {
      rowKind            kind;
      logic [15:0]       newPC;       // Redirect target
      stageInfo          d, x, m, w;
      logic              bubble;      // Expected bubble flag
      fwdSel             fwdA, fwdB;  // Expected selects
   } rowT;

   logic clk = 1'b0;
   logic reset;
   logic [15:0] newPC;
   logic createDump;
   stageInfo stageD, stageX, stageM, stageW;
   logic loadEn;
   logic [15:0] loadAddr, loadData;
   fetchOut fetched;
   fwdCtrl fwd;
   logic stall, alignErr, err;

   logic [15:0] prog [memWords];   // Copy of the preloaded program
   rowT rows [numRows];
   logic [31:0] lcgState = 32'h937b;
   logic [15:0] nextPc;            // Address of the access now in flight
   logic [12:0] lineTag;           // Model of the buffered line
   logic tagValid;

   fetch #(.missLatency(missLat), .memWords(memWords)) dut0 (
      .clk(clk), .reset(reset), .newPC(newPC), .createDump(createDump),
      .stageD(stageD), .stageX(stageX), .stageM(stageM), .stageW(stageW),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .fetched(fetched), .fwd(fwd), .stall(stall), .alignErr(alignErr), .err(err)
   );

   always #10 clk = ~clk;   // 20 ns period

   // Watchdog sized from the table length
   initial begin
      #(limitCyc * 20);
      $display("Timeout: the DUT stopped delivering instructions");
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   function automatic logic [15:0] encodeInstr(instrOp op, int rs, int rt);
      return {op, 3'(rs), 3'(rt), 5'b0};
   endfunction

   function automatic stageInfo stageStatus(logic wr, int rg, logic ld, logic br);
      return '{regWrt: wr, wrtReg: 3'(rg), isLoad: ld, isBranch: br};
   endfunction

   function automatic rowT buildRow(rowKind k, logic [15:0] pc, stageInfo d, stageInfo x,
                                    stageInfo m, stageInfo w, logic b, fwdSel fa, fwdSel fb);
      return '{kind: k, newPC: pc, d: d, x: x, m: m, w: w, bubble: b, fwdA: fa, fwdB: fb};
   endfunction

   // Hit or miss against the modelled line, refills on a miss
   function automatic logic touchLine(logic [15:0] a);
      logic miss;
      miss = !a[0] && !(tagValid && (a[15:3] == lineTag));
      if (miss) begin
         lineTag  = a[15:3];
         tagValid = 1'b1;
      end
      return miss;
   endfunction

   task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic runRow(input int i);
      rowT r;
      int stalls;
      logic [15:0] pc;
      logic miss;
      logic [15:0] expWord;
      r = rows[i];
      stalls = 0;
      if (r.kind == kRedir) begin
         void'(touchLine(nextPc));         // Let the access in flight finish
         @(negedge clk);
         while (stall) @(negedge clk);
         newPC = r.newPC;
         stageD = r.d;
         stageX = r.x;
         stageM = r.m;
         stageW = stageStatus(0, 0, 0, 1);   // Branch resolved in W for one cycle
         createDump = 1'b0;
         @(negedge clk);
         stageW = r.w;
         nextPc = r.newPC;
      end else begin
         @(negedge clk);
         stageD = r.d;
         stageX = r.x;
         stageM = r.m;
         stageW = r.w;
         createDump = (r.kind == kDump);
      end
      pc = nextPc;
      miss = touchLine(pc);
      #2;
      while (!fetched.instrValid) begin
         if (stall) stalls++;
         @(negedge clk);
         #2;
      end
      expWord = (r.bubble || pc[0]) ? nopWord : prog[pc[8:1]];
      checkVal("stallCycles", 16'(stalls), miss ? 16'(missLat) : 16'd0);
      checkVal("instruction", fetched.instruction, expWord);
      checkVal("incPC", fetched.incPC, pc + 16'd2);
      checkVal("bubble", 16'(fetched.bubble), 16'(r.bubble));
      checkVal("fwdA", 16'(fwd.fwdA), 16'(r.fwdA));
      checkVal("fwdB", 16'(fwd.fwdB), 16'(r.fwdB));
      checkVal("alignErr", 16'(alignErr), 16'(pc[0]));
      checkVal("err", 16'(err), 16'(pc == 16'hFFFE));
      if (r.kind == kDump) begin
         repeat (3) begin                  // Frozen, nothing new arrives
            @(negedge clk);
            #2;
            checkVal("instrValid", 16'(fetched.instrValid), 16'd0);
            checkVal("incPC", fetched.incPC, pc + 16'd2);
         end
      end
      nextPc = (r.bubble || r.kind == kDump) ? pc : pc + 16'd2;
   endtask

   task automatic fillTable();
      stageInfo n;
      n = '0;
      rows[0]  = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);   // Cold miss
      rows[1]  = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);
      rows[2]  = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);
      rows[3]  = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);
      rows[4]  = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);   // Next line
      rows[5]  = buildRow(kPlain, 0, stageStatus(0, 0, 0, 1), n, n, n, 1, fwdNone, fwdNone);
      rows[6]  = buildRow(kPlain, 0, n, stageStatus(0, 0, 0, 1), n, n, 1, fwdNone, fwdNone);
      rows[7]  = buildRow(kPlain, 0, n, n, stageStatus(0, 0, 0, 1), n, 1, fwdNone, fwdNone);
      rows[8]  = buildRow(kPlain, 0, n, n, n, stageStatus(1, 7, 0, 0), 0, fwdW, fwdNone);
      rows[9]  = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);
      rows[10] = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);
      rows[11] = buildRow(kRedir, 16'h0000, n, stageStatus(1, 1, 0, 0),
                          stageStatus(1, 1, 0, 0), stageStatus(1, 2, 0, 0), 0, fwdX, fwdW);
      rows[12] = buildRow(kPlain, 0, n, stageStatus(1, 3, 1, 0), stageStatus(1, 3, 0, 0), n,
                          0, fwdM, fwdNone);
      rows[13] = buildRow(kPlain, 0, n, stageStatus(1, 4, 1, 0), n, stageStatus(1, 4, 0, 0),
                          0, fwdW, fwdNone);
      rows[14] = buildRow(kPlain, 0, stageStatus(1, 6, 1, 0), n, n, n, 1, fwdNone, fwdNone);
      rows[15] = buildRow(kPlain, 0, n, stageStatus(1, 5, 0, 0), stageStatus(1, 6, 0, 0), n,
                          0, fwdX, fwdM);
      rows[16] = buildRow(kPlain, 0, stageStatus(1, 1, 1, 0), n, n, n, 1, fwdNone, fwdNone);
      rows[17] = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);   // Same word again
      rows[18] = buildRow(kDump, 0, n, n, n, n, 0, fwdNone, fwdNone);
      rows[19] = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);
      rows[20] = buildRow(kRedir, 16'h000B, n, n, n, n, 0, fwdNone, fwdNone);   // Odd target
      rows[21] = buildRow(kRedir, 16'hFFFE, n, n, n, n, 0, fwdNone, fwdNone);   // Carry out
      rows[22] = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);   // Wrapped to 0
      rows[23] = buildRow(kPlain, 0, n, n, n, n, 0, fwdNone, fwdNone);
   endtask

   initial begin
      reset = 1'b1;
      newPC = '0;
      createDump = 1'b1;   // Keeps the PC still during preload
      stageD = '0;
      stageX = '0;
      stageM = '0;
      stageW = '0;
      loadEn = 1'b0;
      loadAddr = '0;
      loadData = '0;
      tagValid = 1'b0;
      lineTag = '0;
      nextPc = '0;
      prog[0] = encodeInstr(opAlu, 1, 2);
      prog[1] = encodeInstr(opAddi, 3, 0);
      prog[2] = encodeInstr(opLd, 4, 0);
      prog[3] = encodeInstr(opSt, 5, 6);
      prog[4] = encodeInstr(opAlu, 1, 2);
      prog[5] = encodeInstr(opBeqz, 7, 0);
      prog[6] = encodeInstr(opJ, 0, 0);
      prog[7] = nopWord;
      for (int i = 8; i < memWords; i++) begin
         prog[i] = {opAlu, 11'(nextRand() ^ 32'(i))};   // Random body, forced ALU opcode
      end
      fillTable();
      repeat (resetCyc) @(negedge clk);
      checkVal("instrValid", 16'(fetched.instrValid), 16'd0);
      checkVal("bubble", 16'(fetched.bubble), 16'd0);
      checkVal("stall", 16'(stall), 16'd0);
      checkVal("alignErr", 16'(alignErr), 16'd0);
      checkVal("err", 16'(err), 16'd0);
      reset = 1'b0;
      for (int i = 0; i < memWords; i++) begin
         @(negedge clk);
         loadEn = 1'b1;
         loadAddr = 16'(i * 2);
         loadData = prog[i];
      end
      @(negedge clk);
      loadEn = 1'b0;
      for (int i = 0; i < numRows; i++) begin
         runRow(i);
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: filelist.f
verilog/fetchPkg.sv
verilog/instrMemory.sv
verilog/hazardDetect.sv
verilog/fetch.sv
verification/fetchTb.sv

// File: Makefile
# Verilator build and run for the fetch stage testbench
# Any variable can be overridden on the command line, e.g. make run TOP=fetchTb

VERILATOR  ?= verilator
TOP        ?= fetchTb
OBJ_DIR    ?= obj_dir
FILELIST   ?= filelist.f
VFLAGS     ?= --binary --timing --assert
EXTRA      ?=

SRCS := $(wildcard verilog/*.sv) $(wildcard verification/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits non-zero on $fatal, so make fails with it
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
